// ==== logic/x25519_pkg.sv ====
package x25519_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field element layout

	// 256-bit operands as 32 byte limbs, little endian
	localparam int NUM_LIMBS  = 32;
	localparam int LIMB_IDX_W = $clog2(NUM_LIMBS);

	typedef logic [LIMB_IDX_W-1:0] limb_idx_t;

	// Input and result limb
	typedef logic [7:0] limb_t;

	// Wide limb, large enough for one full product column
	typedef logic [31:0] acc_t;

	typedef struct packed {
		limb_t [NUM_LIMBS-1:0] limb;
	} fe_t;

	typedef acc_t [NUM_LIMBS-1:0] fe_acc_t;

	// p = 2^255 - 19, so weight 2^256 folds to 38 and 2^255 folds to 19
	localparam acc_t FOLD_MULT_HIGH = 32'd38;
	localparam acc_t FOLD_MULT_TOP  = 32'd19;

	////////////////////////////////////////////////////////////////////////////
	// FSM states and inter-block transfers

	typedef enum logic [1:0] {IDLE, RUN, DRAIN} seq_state_t;
	typedef enum logic [1:0] {COLLECT, FOLD, CARRY2} sqz_state_t;

	// One pass request, valid is a single-cycle start
	typedef struct packed {
		logic      valid;
		limb_idx_t idx;
		fe_t       a;
		fe_acc_t   b;
	} pass_req_t;

	// One product limb, valid is a single-cycle pulse
	typedef struct packed {
		logic      valid;
		limb_idx_t idx;
		acc_t      value;
	} limb_beat_t;

endpackage

// ==== logic/x25519_mult_sequencer.sv ====
`timescale 1ns/1ps

module x25519_mult_sequencer (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   start_i,
	input  x25519_pkg::fe_t        a_i,
	input  x25519_pkg::fe_t        b_i,
	input  x25519_pkg::limb_beat_t beat_i,
	input  logic                   result_done_i,
	output x25519_pkg::pass_req_t  req_o,
	output logic                   busy_o
);

	import x25519_pkg::*;

	seq_state_t state_q;
	logic       req_valid_q;
	limb_idx_t  idx_q;
	logic       accept;
	logic       last_beat;

	// Captured operands, held steady for every pass
	fe_t     a_q;
	fe_acc_t b_rot_q;

	// Start only counts when nothing is in flight
	assign accept    = start_i && (state_q == IDLE);
	assign last_beat = beat_i.valid && (beat_i.idx == limb_idx_t'(NUM_LIMBS - 1));
	assign busy_o    = (state_q != IDLE);

	// Pass unit reads A, B and index for the whole pass
	assign req_o = '{valid: req_valid_q, idx: idx_q, a: a_q, b: b_rot_q};

	////////////////////////////////////////////////////////////////////////////
	// Pass scheduling FSM

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= IDLE;
			req_valid_q <= 1'b0;
			idx_q       <= '0;
		end else begin
			req_valid_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (accept) begin
						state_q     <= RUN;
						idx_q       <= '0;
						req_valid_q <= 1'b1;
					end
				end
				RUN: begin
					// One pass in flight, next one goes out after its beat
					if (last_beat) begin
						state_q <= DRAIN;
					end else if (beat_i.valid) begin
						idx_q       <= idx_q + 1'b1;
						req_valid_q <= 1'b1;
					end
				end
				DRAIN: begin
					// Wait for the second carry pass to finish
					if (result_done_i) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Operand registers

	always_ff @(posedge clk) begin
		if (accept) begin
			a_q <= a_i;
			// Limb 0 stays, the rest go in reversed, so b_rot[j] = b[-j mod 32]
			for (int k = 0; k < NUM_LIMBS; k++) begin
				b_rot_q[k] <= acc_t'(b_i.limb[(NUM_LIMBS - k) % NUM_LIMBS]);
			end
		end else if (beat_i.valid) begin
			// Rotate up by one limb, so pass i sees b[i - j mod 32]
			b_rot_q <= {b_rot_q[NUM_LIMBS-2:0], b_rot_q[NUM_LIMBS-1]};
		end
	end

endmodule

// ==== logic/x25519_mult_pass.sv ====
`timescale 1ns/1ps

module x25519_mult_pass (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  x25519_pkg::pass_req_t  req_i,
	output x25519_pkg::limb_beat_t beat_o
);

	import x25519_pkg::*;

	// Column walk
	logic      active_q;
	limb_idx_t j_q;
	limb_idx_t out_idx_q;
	logic      beat_valid_q;
	logic      last_step;

	// Running column sum
	acc_t acc_q;
	acc_t prod;
	acc_t term;
	acc_t sum;

	////////////////////////////////////////////////////////////////////////////
	// One multiply-accumulate per cycle

	always_comb begin
		// a[j] times the matching limb of the rotated B
		prod = acc_t'(req_i.a.limb[j_q]) * req_i.b[j_q];
		// Terms past the diagonal wrap around 2^256 and fold back by 38
		term = (j_q > req_i.idx) ? prod * FOLD_MULT_HIGH : prod;
		// Column restarts from zero on a new request
		sum  = (active_q ? acc_q : '0) + term;
	end

	assign last_step = active_q && (j_q == limb_idx_t'(NUM_LIMBS - 1));

	////////////////////////////////////////////////////////////////////////////
	// Pass control

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			active_q     <= 1'b0;
			j_q          <= '0;
			beat_valid_q <= 1'b0;
		end else begin
			beat_valid_q <= last_step;
			if (req_i.valid || active_q) begin
				// Counter wraps back to 0 after limb 31
				j_q <= j_q + 1'b1;
			end
			if (req_i.valid) begin
				active_q <= 1'b1;
			end else if (last_step) begin
				active_q <= 1'b0;
			end
		end
	end

	// Accumulator holds the finished column through the beat cycle
	always_ff @(posedge clk) begin
		if (req_i.valid || active_q) begin
			acc_q <= sum;
		end
		if (req_i.valid) begin
			out_idx_q <= req_i.idx;
		end
	end

	assign beat_o = '{valid: beat_valid_q, idx: out_idx_q, value: acc_q};

endmodule

// ==== logic/x25519_streaming_squeeze.sv ====
`timescale 1ns/1ps

module x25519_streaming_squeeze (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  x25519_pkg::limb_beat_t beat_i,
	output logic                   out_valid_o,
	output x25519_pkg::fe_t        out_o,
	output logic                   done_o
);

	import x25519_pkg::*;

	sqz_state_t state_q;
	limb_idx_t  k_q;
	logic       out_valid_q;
	logic       beat_last;
	logic       k_last;

	// First pass carry on arriving beats
	acc_t carry1_q;
	acc_t sum1;

	// Bits at and above 2^255 after the first pass
	acc_t top_q;

	// Second pass carry through the result buffer
	acc_t carry2_q;
	acc_t sum2;

	// Byte buffer for the first pass and result buffer for the second
	fe_acc_t col_q;
	fe_acc_t res_q;

	assign beat_last = beat_i.valid && (beat_i.idx == limb_idx_t'(NUM_LIMBS - 1));
	assign k_last    = (k_q == limb_idx_t'(NUM_LIMBS - 1));

	always_comb begin
		sum1 = carry1_q + beat_i.value;
		sum2 = carry2_q + res_q[k_q];
	end

	////////////////////////////////////////////////////////////////////////////
	// First carry pass in the beat cycle

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			carry1_q <= '0;
		end else if (beat_i.valid) begin
			// Next element starts with a clean carry
			carry1_q <= beat_last ? '0 : (sum1 >> 8);
		end
	end

	always_ff @(posedge clk) begin
		if (beat_i.valid) begin
			if (beat_last) begin
				// Top limb keeps 7 bits and the rest is worth 2^255
				col_q[NUM_LIMBS-1] <= {25'd0, sum1[6:0]};
				top_q              <= sum1 >> 7;
			end else begin
				col_q[beat_i.idx] <= {24'd0, sum1[7:0]};
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Fold and second carry pass

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= COLLECT;
			k_q         <= '0;
			out_valid_q <= 1'b0;
		end else begin
			out_valid_q <= 1'b0;
			case (state_q)
				COLLECT: begin
					if (beat_last) begin
						state_q <= FOLD;
					end
				end
				FOLD: begin
					state_q <= CARRY2;
					k_q     <= '0;
				end
				CARRY2: begin
					k_q <= k_q + 1'b1;
					if (k_last) begin
						state_q     <= COLLECT;
						out_valid_q <= 1'b1;
					end
				end
				default: state_q <= COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state_q)
			FOLD: begin
				// Hand over so that collection of the next element can start
				res_q    <= col_q;
				carry2_q <= top_q * FOLD_MULT_TOP;
			end
			CARRY2: begin
				// Top limb ends at most 128 and never carries out
				res_q[k_q] <= {24'd0, sum2[7:0]};
				carry2_q   <= sum2 >> 8;
			end
			default: begin
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Result

	always_comb begin
		for (int k = 0; k < NUM_LIMBS; k++) begin
			out_o.limb[k] = res_q[k][7:0];
		end
	end

	assign out_valid_o = out_valid_q;
	assign done_o      = out_valid_q;

endmodule

// ==== logic/x25519_mult.sv ====
`timescale 1ns/1ps

module x25519_mult (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            start_i,
	input  x25519_pkg::fe_t a_i,
	input  x25519_pkg::fe_t b_i,
	output logic            busy_o,
	output logic            out_valid_o,
	output x25519_pkg::fe_t out_o
);

	import x25519_pkg::*;

	// Sequencer to pass unit
	pass_req_t req;

	// Pass unit to sequencer and squeeze unit
	limb_beat_t beat;

	// Squeeze finished, lets the sequencer go idle
	logic result_done;

	////////////////////////////////////////////////////////////////////////////
	// Operand capture and pass scheduling

	x25519_mult_sequencer i_sequencer (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.start_i       (start_i),
		.a_i           (a_i),
		.b_i           (b_i),
		.beat_i        (beat),
		.result_done_i (result_done),
		.req_o         (req),
		.busy_o        (busy_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// One product limb per pass

	x25519_mult_pass i_pass (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (req),
		.beat_o   (beat)
	);

	////////////////////////////////////////////////////////////////////////////
	// Carry and reduce as limbs arrive

	x25519_streaming_squeeze i_squeeze (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.beat_i      (beat),
		.out_valid_o (out_valid_o),
		.out_o       (out_o),
		.done_o      (result_done)
	);

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic arst_n_o
);

	// 8 ns period
	localparam int HALF_PERIOD = 4;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// Reset low for the first two rising edges, released on the second
	initial begin
		arst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		arst_n_o <= 1'b1;
	end

endmodule

// ==== test/x25519_mult_assertions.sv ====
`timescale 1ns/1ps

module x25519_mult_assertions (
	input logic clk,
	input logic arst_n_i,
	input logic start_i,
	input logic busy_i,
	input logic out_valid_i
);

	// Failed checks so far, read by the testbench summary
	int unsigned fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// Result handshake

	// Result pulse is exactly one cycle wide
	a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
		out_valid_i |=> !out_valid_i)
	else begin
		$error("out_valid_o stayed high for more than one cycle");
		fail_count++;
	end

	// A result only comes out of a run that was already going
	a_valid_in_run: assert property (@(posedge clk) disable iff (!arst_n_i)
		out_valid_i |-> busy_i && $past(busy_i))
	else begin
		$error("out_valid_o without busy_o before it");
		fail_count++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Start handling

	// Busy only rises from a start seen while idle
	a_busy_from_start: assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(busy_i) |-> $past(start_i))
	else begin
		$error("busy_o rose without a start");
		fail_count++;
	end

	// Starts pulsed during a run never keep it going past its result
	a_run_ends: assert property (@(posedge clk) disable iff (!arst_n_i)
		out_valid_i |=> !busy_i)
	else begin
		$error("busy_o still high after the result, a start was taken while busy");
		fail_count++;
	end

	// Idle and quiet right out of reset
	a_reset_quiet: assert property (@(posedge clk)
		$rose(arst_n_i) |-> !busy_i && !out_valid_i)
	else begin
		$error("busy_o or out_valid_o active after reset");
		fail_count++;
	end

endmodule

bind x25519_mult x25519_mult_assertions i_assertions (
	.clk         (clk),
	.arst_n_i    (arst_n_i),
	.start_i     (start_i),
	.busy_i      (busy_o),
	.out_valid_i (out_valid_o)
);

// ==== test/tb_x25519_mult.sv ====
`timescale 1ns/1ps

module tb_x25519_mult;

	import x25519_pkg::*;

	localparam int          TIMEOUT_CYCLES = 1200;
	localparam int          RANDOM_PAIRS   = 20;
	localparam int          BURST_LEN      = 4;
	localparam logic [31:0] LFSR_SEED      = 32'h2f09210f;

	logic clk;
	logic arst_n_i;
	logic start_i;
	fe_t  a_i;
	fe_t  b_i;
	logic busy_o;
	logic out_valid_o;
	fe_t  out_o;

	// Run bookkeeping
	logic [31:0] lfsr_state;
	int unsigned errors;
	int unsigned errors_at_start;
	int unsigned checks;
	int unsigned tests_run;
	int unsigned tests_failed;
	logic        timed_out;

	tb_clock_gen i_clock_gen (.clk_o(clk), .arst_n_o(arst_n_i));

	x25519_mult i_dut (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.start_i     (start_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.busy_o      (busy_o),
		.out_valid_o (out_valid_o),
		.out_o       (out_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus source and reference model

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per operand bit
	task automatic rand_fe(output fe_t v);
		logic [255:0] bits;
		for (int k = 0; k < 256; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits[k]    = lfsr_state[0];
		end
		v = fe_t'(bits);
	endtask

	// Reference limb products followed by the two-pass squeeze
	function automatic fe_t ref_mult(input fe_t a, input fe_t b);
		logic [31:0] t [NUM_LIMBS];
		logic [31:0] u;
		fe_t         r;
		for (int i = 0; i < NUM_LIMBS; i++) begin
			u = 32'd0;
			for (int j = 0; j < NUM_LIMBS; j++) begin
				if (j <= i) begin
					u = u + 32'(a.limb[j]) * 32'(b.limb[i - j]);
				end else begin
					// Weight 2^256 wraps to 38
					u = u + 32'd38 * 32'(a.limb[j]) * 32'(b.limb[i + NUM_LIMBS - j]);
				end
			end
			t[i] = u;
		end
		u = 32'd0;
		for (int j = 0; j < NUM_LIMBS - 1; j++) begin
			u    = u + t[j];
			t[j] = u & 32'd255;
			u    = u >> 8;
		end
		u                = u + t[NUM_LIMBS-1];
		t[NUM_LIMBS-1]   = u & 32'd127;
		// Everything from 2^255 up comes back times 19
		u = 32'd19 * (u >> 7);
		for (int j = 0; j < NUM_LIMBS - 1; j++) begin
			u    = u + t[j];
			t[j] = u & 32'd255;
			u    = u >> 8;
		end
		t[NUM_LIMBS-1] = u + t[NUM_LIMBS-1];
		for (int j = 0; j < NUM_LIMBS; j++) begin
			r.limb[j] = t[j][7:0];
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Handshake helpers called right after a rising edge

	task automatic wait_reset_release();
		int unsigned n;
		n = 0;
		while (arst_n_i !== 1'b1 && !timed_out) begin
			if (n == TIMEOUT_CYCLES) begin
				timed_out = 1'b1;
				$display("Timeout: reset never released");
			end else begin
				@(posedge clk);
				n++;
			end
		end
	endtask

	task automatic wait_idle();
		int unsigned n;
		n = 0;
		while (busy_o && !timed_out) begin
			if (n == TIMEOUT_CYCLES) begin
				timed_out = 1'b1;
				$display("Timeout: DUT still busy after %0d cycles", TIMEOUT_CYCLES);
			end else begin
				@(posedge clk);
				n++;
			end
		end
	endtask

	// Start high for one cycle with the operands alongside
	task automatic issue_start(input fe_t a, input fe_t b);
		start_i <= 1'b1;
		a_i     <= a;
		b_i     <= b;
		@(posedge clk);
		start_i <= 1'b0;
	endtask

	task automatic wait_result(output fe_t r);
		int unsigned n;
		logic        seen;
		n    = 0;
		seen = 1'b0;
		r    = '0;
		while (!seen && !timed_out) begin
			if (n == TIMEOUT_CYCLES) begin
				timed_out = 1'b1;
				$display("Timeout: no result after %0d cycles", TIMEOUT_CYCLES);
			end else begin
				@(posedge clk);
				n++;
				// Values read at the edge belong to the cycle just ended
				if (out_valid_o) begin
					seen = 1'b1;
					r    = out_o;
				end
			end
		end
	endtask

	task automatic check_result(input string label, input fe_t got, input fe_t exp);
		if (!timed_out) begin
			checks++;
			assert (got == exp) else begin
				errors++;
				$display("[ERROR] %0t ns: %s gave %h, expected %h", $time, label, got, exp);
			end
		end
	endtask

	task automatic run_mult(input string label, input fe_t a, input fe_t b);
		fe_t got;
		wait_idle();
		issue_start(a, b);
		wait_result(got);
		check_result(label, got, ref_mult(a, b));
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors != errors_at_start || timed_out) begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - errors_at_start);
		end else begin
			$display("Test %s: passed", name);
		end
		errors_at_start = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test cases

	task automatic mult_by_zero_and_one();
		fe_t x;
		fe_t one;
		rand_fe(x);
		one = fe_t'(256'd1);
		run_mult("zero x random", '0, x);
		run_mult("random x zero", x, '0);
		run_mult("one x random", one, x);
		run_mult("random x one", x, one);
	endtask

	task automatic random_pairs();
		fe_t x;
		fe_t y;
		for (int k = 0; k < RANDOM_PAIRS; k++) begin
			rand_fe(x);
			rand_fe(y);
			run_mult("random pair", x, y);
		end
	endtask

	task automatic all_ones_operands();
		fe_t ones;
		ones = fe_t'({256{1'b1}});
		run_mult("all 0xff limbs", ones, ones);
	endtask

	task automatic start_while_busy();
		fe_t x;
		fe_t y;
		fe_t z;
		fe_t got;
		int  extra;
		rand_fe(x);
		rand_fe(y);
		rand_fe(z);
		wait_idle();
		issue_start(x, y);
		repeat (100) @(posedge clk);
		assert (busy_o) else begin
			errors++;
			$display("DUT was not busy when the second start was pulsed");
		end
		issue_start(z, z);
		wait_result(got);
		check_result("start while busy", got, ref_mult(x, y));
		// A wrongly taken start would deliver inside this window
		extra = 0;
		if (!timed_out) begin
			for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
				@(posedge clk);
				if (out_valid_o) begin
					extra++;
				end
			end
			assert (extra == 0 && !busy_o) else begin
				errors++;
				$display("Start during a run was taken, %0d extra results", extra);
			end
		end
	endtask

	task automatic operands_change_after_start();
		fe_t x;
		fe_t y;
		fe_t got;
		rand_fe(x);
		rand_fe(y);
		wait_idle();
		issue_start(x, y);
		// Inputs move on as soon as the start is taken
		a_i <= ~x;
		b_i <= ~y;
		wait_result(got);
		check_result("operands changed", got, ref_mult(x, y));
	endtask

	task automatic back_to_back_requests();
		fe_t op_a [BURST_LEN];
		fe_t op_b [BURST_LEN];
		fe_t got;
		for (int k = 0; k < BURST_LEN; k++) begin
			rand_fe(op_a[k]);
			rand_fe(op_b[k]);
		end
		wait_idle();
		issue_start(op_a[0], op_b[0]);
		for (int k = 0; k < BURST_LEN; k++) begin
			wait_result(got);
			// Busy drops at this edge and the next start lands in its first idle cycle
			if (k < BURST_LEN - 1) begin
				issue_start(op_a[k + 1], op_b[k + 1]);
			end
			check_result("back-to-back", got, ref_mult(op_a[k], op_b[k]));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		start_i         <= 1'b0;
		a_i             <= '0;
		b_i             <= '0;
		lfsr_state      = LFSR_SEED;
		errors          = 0;
		errors_at_start = 0;
		checks          = 0;
		tests_run       = 0;
		tests_failed    = 0;
		timed_out       = 1'b0;
		wait_reset_release();
		mult_by_zero_and_one();
		report_test("zero and one operands");
		random_pairs();
		report_test("random operand pairs");
		all_ones_operands();
		report_test("all 0xff operands");
		start_while_busy();
		report_test("start while busy ignored");
		operands_change_after_start();
		report_test("operand change after start");
		back_to_back_requests();
		report_test("back-to-back requests");
		$display("Summary: %0d run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests_run, tests_failed, checks, errors, i_dut.i_assertions.fail_count);
		if (errors == 0 && tests_failed == 0 && i_dut.i_assertions.fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
logic/x25519_pkg.sv
logic/x25519_mult_sequencer.sv
logic/x25519_mult_pass.sv
logic/x25519_streaming_squeeze.sv
logic/x25519_mult.sv
test/tb_clock_gen.sv
test/x25519_mult_assertions.sv
test/tb_x25519_mult.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_x25519_mult \
	-f src.f \
	-o sim_x25519_mult

# Assertion errors are counted by the testbench, so the run goes on past them
./obj_dir/sim_x25519_mult +verilator+error+limit+1000 | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi
